// ==== rtl/noc_pkg.sv ====
// Shared widths, flit format and state types, referenced by scoped names across the output stage
package noc_pkg;

	// ************************************************************
	// Widths
	// ************************************************************

	// Payload bits carried by one flit
	localparam int flit_width = 16;

	// Source peers sharing the output link
	localparam int num_sources = 4;

	// Length field holds flit count minus one, so 1 to 8 flits
	localparam int len_width = 3;

	// ************************************************************
	// Policy and state encodings
	// ************************************************************

	typedef enum logic [1:0] {
		arb_round_robin,
		arb_fixed_priority,
		arb_qos
	} arb_mode_e;

	typedef enum logic {
		link_idle,
		link_in_packet
	} link_state_e;

	typedef enum logic {
		src_idle,
		src_sending
	} src_state_e;

	// One flit on the link, last marks the packet tail
	typedef struct packed {
		logic last;
		logic [flit_width-1:0] data;
	} flit_t;

endpackage

// ==== rtl/flit_link_if.sv ====
// Flit stream from one source to the arbiter, with ready returned; used once per source
`timescale 1ns/1ps

interface flit_link_if #(
	parameter int flit_width = noc_pkg::flit_width
);

	// A flit moves when valid and ready are both high at a rising edge
	logic valid;
	noc_pkg::flit_t flit;
	logic ready;

	// Source holds valid and flit steady until accepted
	modport source (
		output valid,
		output flit,
		input ready
	);

	modport arbiter (
		input valid,
		input flit,
		output ready
	);

	// Payload width must agree with the shared flit type
	if (flit_width != noc_pkg::flit_width)
	begin : g_width_check
		$error("flit_link_if payload width differs from noc_pkg::flit_t");
	end

endinterface

// ==== rtl/packet_source.sv ====
// Source peer that queues packet commands and sends each packet as a counting flit stream on its link
`timescale 1ns/1ps

module packet_source #(
	parameter int flit_width = noc_pkg::flit_width,
	parameter int queue_depth = 4
) (
	input logic munoc_port_3,
	input logic munoc_port_1,
	input logic cmd_valid,
	input logic [noc_pkg::len_width-1:0] cmd_len,
	input logic [flit_width-1:0] cmd_base,
	output logic cmd_full,
	flit_link_if.source link
);

	localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_width = $clog2(queue_depth + 1);

	// ************************************************************
	// Command queue
	// ************************************************************

	logic [noc_pkg::len_width-1:0] len_mem [queue_depth];
	logic [flit_width-1:0] base_mem [queue_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [cnt_width-1:0] count;
	logic push;
	logic pop;
	logic accept;

	// Flit generation state
	noc_pkg::src_state_e state;
	logic [noc_pkg::len_width-1:0] flit_idx;
	logic [flit_width-1:0] data_q;
	logic [flit_width-1:0] flit_data;
	logic flit_last;
	noc_pkg::flit_t flit_out;

	assign cmd_full = (count == cnt_width'(queue_depth));
	assign push = cmd_valid && !cmd_full;
	assign accept = link.valid && link.ready;
	// Head command retires with its last flit
	assign pop = accept && flit_last;

	always_ff @(posedge munoc_port_3)
	begin
		if (push)
		begin
			len_mem[wr_ptr] <= cmd_len;
			base_mem[wr_ptr] <= cmd_base;
		end
	end

	always_ff @(posedge munoc_port_3 or negedge munoc_port_1)
	begin
		if (!munoc_port_1)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// ************************************************************
	// Flit stream
	// ************************************************************

	// First flit comes straight from the queue head, later ones from the running payload
	assign flit_data = (state == noc_pkg::src_idle) ? base_mem[rd_ptr] : data_q;
	assign flit_last = (flit_idx == len_mem[rd_ptr]);

	always_comb
	begin
		flit_out.last = flit_last;
		flit_out.data = flit_data;
	end

	assign link.valid = (count != '0);
	assign link.flit = flit_out;

	always_ff @(posedge munoc_port_3 or negedge munoc_port_1)
	begin
		if (!munoc_port_1)
		begin
			state <= noc_pkg::src_idle;
			flit_idx <= '0;
		end
		else if (accept)
		begin
			if (flit_last)
			begin
				state <= noc_pkg::src_idle;
				flit_idx <= '0;
			end
			else
			begin
				state <= noc_pkg::src_sending;
				flit_idx <= flit_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge munoc_port_3)
	begin
		if (accept)
			data_q <= flit_data + 1'b1;
	end

	// A presented flit stays offered and unchanged until the arbiter takes it
	a_valid_held: assert property (@(posedge munoc_port_3) disable iff (!munoc_port_1)
		link.valid && !link.ready |=> link.valid && $stable(link.flit));

endmodule

// ==== rtl/packet_arbiter.sv ====
// Packet-locked arbiter for the output link; policy chosen by parameter, grant held per packet
`timescale 1ns/1ps

module packet_arbiter #(
	parameter int num_sources = noc_pkg::num_sources,
	parameter noc_pkg::arb_mode_e arb_mode = noc_pkg::arb_qos
) (
	input logic munoc_port_3,
	input logic munoc_port_1,
	input logic [num_sources-1:0] request,
	input logic [num_sources-1:0] last,
	input logic [num_sources-1:0] enable,
	input logic out_ready,
	output logic [num_sources-1:0] ready,
	output logic [num_sources-1:0] grant,
	output logic out_valid
);

	// ************************************************************
	// Owner and request view
	// ************************************************************

	logic [num_sources-1:0] owner_ptr;
	logic [num_sources-1:0] ptr_next;
	logic [num_sources-1:0] served;
	noc_pkg::link_state_e link_state;

	logic [num_sources-1:0] req;
	logic owner_req;
	logic owner_last;
	logic accept;
	logic tail_accept;
	logic advance;

	// Candidate sets for the next owner
	logic [num_sources-1:0] other_req;
	logic [num_sources-1:0] other_first;
	logic other_any;
	logic [num_sources-1:0] unserved_req;
	logic [num_sources-1:0] unserved_first;
	logic unserved_any;

	// Disabled sources are invisible to arbitration
	assign req = request & enable;
	assign owner_req = |(req & owner_ptr);
	assign owner_last = |(last & owner_ptr);
	assign accept = owner_req && out_ready;
	assign tail_accept = accept && owner_last;

	// Move on after a tail, or when an idle owner has nothing to send
	assign advance = tail_accept || (link_state == noc_pkg::link_idle && !owner_req);

	assign other_req = req & ~owner_ptr;
	assign other_first = other_req & (~other_req + num_sources'(1));
	assign other_any = |other_req;

	assign unserved_req = other_req & ~served;
	assign unserved_first = unserved_req & (~unserved_req + num_sources'(1));
	assign unserved_any = |unserved_req;

	// ************************************************************
	// Next owner per policy
	// ************************************************************

	always_comb
	begin
		ptr_next = owner_ptr;
		case (arb_mode)
			noc_pkg::arb_round_robin:
				for (int j = 0; j < num_sources; j++)
					ptr_next[j] = owner_ptr[(j + num_sources - 1) % num_sources];
			noc_pkg::arb_fixed_priority:
				if (other_any)
					ptr_next = other_first;
			noc_pkg::arb_qos:
				if (unserved_any)
					ptr_next = unserved_first;
				else if (other_any)
					ptr_next = other_first;
			default:
				ptr_next = owner_ptr;
		endcase
	end

	// ************************************************************
	// Pointer, served mask and link state
	// ************************************************************

	always_ff @(posedge munoc_port_3 or negedge munoc_port_1)
	begin
		if (!munoc_port_1)
			owner_ptr <= num_sources'(1);
		else if (advance)
			owner_ptr <= ptr_next;
	end

	// Round is over once no unserved requester remains
	always_ff @(posedge munoc_port_3 or negedge munoc_port_1)
	begin
		if (!munoc_port_1)
			served <= '0;
		else if (advance)
		begin
			if (!unserved_any)
				served <= '0;
			else if (tail_accept)
				served <= served | owner_ptr;
		end
	end

	always_ff @(posedge munoc_port_3 or negedge munoc_port_1)
	begin
		if (!munoc_port_1)
			link_state <= noc_pkg::link_idle;
		else
		begin
			case (link_state)
				noc_pkg::link_idle:
					if (accept && !owner_last)
						link_state <= noc_pkg::link_in_packet;
				noc_pkg::link_in_packet:
					if (tail_accept)
						link_state <= noc_pkg::link_idle;
				default:
					link_state <= noc_pkg::link_idle;
			endcase
		end
	end

	assign ready = owner_ptr & enable & {num_sources{out_ready}};
	assign grant = owner_ptr;
	assign out_valid = owner_req;

	a_grant_onehot: assert property (@(posedge munoc_port_3) disable iff (!munoc_port_1)
		$onehot(grant));

	// No other source may cut into a packet already on the link
	a_grant_locked: assert property (@(posedge munoc_port_3) disable iff (!munoc_port_1)
		link_state == noc_pkg::link_in_packet |-> $stable(grant));

endmodule

// ==== rtl/output_port.sv ====
// Output port: arbitrates the source links and muxes the granted flit onto the output link
`timescale 1ns/1ps

module output_port #(
	parameter int num_sources = noc_pkg::num_sources,
	parameter int flit_width = noc_pkg::flit_width,
	parameter noc_pkg::arb_mode_e arb_mode = noc_pkg::arb_qos
) (
	input logic munoc_port_3,
	input logic munoc_port_1,
	flit_link_if.arbiter links [num_sources],
	input logic [num_sources-1:0] enable,
	input logic out_ready,
	output logic out_valid,
	output noc_pkg::flit_t out_flit
);

	logic [num_sources-1:0] link_valid;
	logic [num_sources-1:0] link_last;
	logic [num_sources-1:0] link_ready;
	logic [num_sources-1:0] grant;
	logic [flit_width:0] link_bits [num_sources];
	logic [flit_width:0] sel_bits;

	// ************************************************************
	// Link gather
	// ************************************************************

	for (genvar i = 0; i < num_sources; i++)
	begin : g_gather
		assign link_valid[i] = links[i].valid;
		assign link_last[i] = links[i].flit.last;
		assign link_bits[i] = links[i].flit;
		assign links[i].ready = link_ready[i];
	end

	packet_arbiter #(
		.num_sources(num_sources),
		.arb_mode(arb_mode)
	) arbiter0 (
		.munoc_port_3(munoc_port_3),
		.munoc_port_1(munoc_port_1),
		.request(link_valid),
		.last(link_last),
		.enable(enable),
		.out_ready(out_ready),
		.ready(link_ready),
		.grant(grant),
		.out_valid(out_valid)
	);

	// One-hot select, no added cycle
	always_comb
	begin
		sel_bits = '0;
		for (int i = 0; i < num_sources; i++)
			sel_bits = sel_bits | (link_bits[i] & {(flit_width + 1){grant[i]}});
	end

	assign out_flit = sel_bits;

	// Stalled output must not change under back-pressure
	a_out_stable: assert property (@(posedge munoc_port_3) disable iff (!munoc_port_1)
		out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

// ==== rtl/noc_output_stage.sv ====
// Top level of one router output port: command ports feed the sources, one link leaves the port
`timescale 1ns/1ps

module noc_output_stage #(
	parameter int num_sources = noc_pkg::num_sources,
	parameter int flit_width = noc_pkg::flit_width,
	parameter noc_pkg::arb_mode_e arb_mode = noc_pkg::arb_qos
) (
	input logic munoc_port_3,
	input logic munoc_port_1,
	input logic cmd_valid,
	input logic [((num_sources > 1) ? $clog2(num_sources) : 1)-1:0] cmd_src,
	input logic [noc_pkg::len_width-1:0] cmd_len,
	input logic [flit_width-1:0] cmd_base,
	output logic [num_sources-1:0] cmd_full,
	input logic [num_sources-1:0] src_enable,
	input logic out_ready,
	output logic out_valid,
	output logic out_last,
	output logic [flit_width-1:0] out_data
);

	localparam int src_width = (num_sources > 1) ? $clog2(num_sources) : 1;

	logic [num_sources-1:0] src_cmd_valid;
	noc_pkg::flit_t port_flit;

	// One link per source, handed to the port as an array
	flit_link_if #(.flit_width(flit_width)) src_link [num_sources] ();

	// ************************************************************
	// Sources
	// ************************************************************

	for (genvar i = 0; i < num_sources; i++)
	begin : g_source
		// Command strobe routed to the addressed source
		assign src_cmd_valid[i] = cmd_valid && (cmd_src == src_width'(i));

		packet_source #(
			.flit_width(flit_width)
		) source0 (
			.munoc_port_3(munoc_port_3),
			.munoc_port_1(munoc_port_1),
			.cmd_valid(src_cmd_valid[i]),
			.cmd_len(cmd_len),
			.cmd_base(cmd_base),
			.cmd_full(cmd_full[i]),
			.link(src_link[i])
		);
	end

	// ************************************************************
	// Output port
	// ************************************************************

	output_port #(
		.num_sources(num_sources),
		.flit_width(flit_width),
		.arb_mode(arb_mode)
	) port0 (
		.munoc_port_3(munoc_port_3),
		.munoc_port_1(munoc_port_1),
		.links(src_link),
		.enable(src_enable),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_flit(port_flit)
	);

	assign out_last = port_flit.last;
	assign out_data = port_flit.data;

endmodule

// ==== test/tb_noc_output_stage.sv ====
// Testbench for the router output stage: replays the tests file and checks every output flit
`timescale 1ns/1ps

module tb_noc_output_stage;

	localparam int num_sources = noc_pkg::num_sources;
	localparam int len_w = noc_pkg::len_width;
	localparam int data_w = noc_pkg::flit_width;

	logic munoc_port_3;
	logic munoc_port_1;
	logic cmd_valid;
	logic [1:0] cmd_src;
	logic [len_w-1:0] cmd_len;
	logic [data_w-1:0] cmd_base;
	logic [num_sources-1:0] cmd_full;
	logic [num_sources-1:0] src_enable;
	logic out_ready;
	logic out_valid;
	logic out_last;
	logic [data_w-1:0] out_data;

	integer seed = 32'h737fc09d;
	int limit_cycles = 0;
	int flit_count = 0;
	logic rand_ready;
	logic [num_sources-1:0] phase_enable;
	noc_pkg::flit_t exp_q [$];
	noc_pkg::flit_t got_q [$];
	string lines [$];

	noc_output_stage #(
		.num_sources(num_sources),
		.flit_width(data_w),
		.arb_mode(noc_pkg::arb_qos)
	) dut0 (
		.munoc_port_3(munoc_port_3),
		.munoc_port_1(munoc_port_1),
		.cmd_valid(cmd_valid),
		.cmd_src(cmd_src),
		.cmd_len(cmd_len),
		.cmd_base(cmd_base),
		.cmd_full(cmd_full),
		.src_enable(src_enable),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_last(out_last),
		.out_data(out_data)
	);

	initial munoc_port_3 = 1'b0;
	always #20 munoc_port_3 = ~munoc_port_3;

	// Flits taken by the link, sampled mid-cycle where outputs are settled
	always @(negedge munoc_port_3)
	begin
		noc_pkg::flit_t seen;
		seen.last = out_last;
		seen.data = out_data;
		if (munoc_port_1 && out_valid && out_ready)
			got_q.push_back(seen);
	end

	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge munoc_port_3);
		abort_run($sformatf("Timeout: output did not drain within %0d cycles", limit_cycles));
	end

	// ************************************************************
	// Helpers
	// ************************************************************

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_flit(input noc_pkg::flit_t got, input noc_pkg::flit_t exp, input int idx);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: flit %0d is last=%0b data=%h, expected last=%0b data=%h",
				$time, idx, got.last, got.data, exp.last, exp.data));
	endtask

	task automatic check_mask(input logic [num_sources-1:0] got,
		input logic [num_sources-1:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge munoc_port_3);
		#2;
	endtask

	// Sources are masked while loading so no arbitration starts early
	task automatic start_phase(input int policy);
		src_enable = '0;
		out_ready = 1'b0;
		rand_ready = (policy != 0);
		phase_enable = '1;
		next_cycle();
	endtask

	task automatic issue_command(input int src, input int len, input int base, input int offset);
		repeat (offset) next_cycle();
		check_mask(cmd_full & (num_sources'(1) << src), '0, "cmd_full of the addressed source");
		cmd_valid = 1'b1;
		cmd_src = 2'(src);
		cmd_len = len_w'(len - 1);
		cmd_base = data_w'(base);
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic drain_phase();
		src_enable = phase_enable;
		while (exp_q.size() > 0)
		begin
			out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
			next_cycle();
			while (got_q.size() > 0 && exp_q.size() > 0)
			begin
				check_flit(got_q.pop_front(), exp_q.pop_front(), flit_count);
				flit_count++;
			end
		end
		if (got_q.size() > 0)
			abort_run("Output link sent a flit that the tests file does not expect");
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************

	initial
	begin
		int fd;
		int n_expected;
		int a, b, c, d;
		byte kind;
		bit phase_open;
		string line;
		noc_pkg::flit_t exp_flit;
		munoc_port_1 = 1'b0;
		cmd_valid = 1'b0;
		cmd_src = '0;
		cmd_len = '0;
		cmd_base = '0;
		src_enable = '0;
		out_ready = 1'b0;
		rand_ready = 1'b0;
		phase_enable = '1;
		phase_open = 1'b0;
		n_expected = 0;
		fd = $fopen("test/noc_output_tests.txt", "r");
		if (fd == 0)
			abort_run("Could not open test/noc_output_tests.txt");
		while ($fgets(line, fd) != 0)
		begin
			lines.push_back(line);
			if (line.getc(0) == "X")
				n_expected++;
		end
		$fclose(fd);
		limit_cycles = 200 * n_expected + 100;

		repeat (5) @(posedge munoc_port_3);
		#2;
		munoc_port_1 = 1'b1;

		foreach (lines[i])
		begin
			kind = lines[i].getc(0);
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			void'($sscanf(lines[i].substr(1, lines[i].len() - 1), "%h %h %h %h", a, b, c, d));
			case (kind)
				"P":
				begin
					if (phase_open)
						drain_phase();
					start_phase(a);
					phase_open = 1'b1;
				end
				"C":
					issue_command(a, b, c, d);
				"E":
					phase_enable = num_sources'(a);
				"X":
				begin
					exp_flit.last = a[0];
					exp_flit.data = data_w'(b);
					exp_q.push_back(exp_flit);
				end
				default:
				begin
				end
			endcase
		end
		if (phase_open)
			drain_phase();

		// Any stray packet would surface here
		out_ready = 1'b1;
		src_enable = '1;
		repeat (10) next_cycle();
		if (got_q.size() > 0 || out_valid)
			abort_run("Output link still active after the last expected flit");
		else
		begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// ==== test/noc_output_tests.txt ====
# P ready_mode (0 always ready, 1 random) | C src length base offset | E enable_mask | X last data
# All fields hex; length counts flits 1 to 8; offset is idle cycles before the command
# All four sources, two packets each, QoS rounds starting at owner 0
P 0
C 0 2 1000 0
C 0 1 1100 0
C 1 1 2000 1
C 1 1 2100 0
C 2 1 3000 0
C 2 1 3100 2
C 3 1 4000 0
C 3 2 4100 0
X 0 1000
X 1 1001
X 1 2000
X 1 3000
X 1 4000
X 1 1100
X 1 2100
X 1 3100
X 0 4100
X 1 4101
# Single source, payload wraps past ffff, owner returns to 0
P 0
C 0 2 0100 0
C 0 3 fffe 1
X 0 0100
X 1 0101
X 0 fffe
X 0 ffff
X 1 0000
# Same load under random back-pressure
P 1
C 0 2 1000 0
C 0 1 1100 0
C 1 1 2000 1
C 1 1 2100 0
C 2 1 3000 0
C 2 1 3100 2
C 3 1 4000 0
C 3 2 4100 0
X 0 1000
X 1 1001
X 1 2000
X 1 3000
X 1 4000
X 1 1100
X 1 2100
X 1 3100
X 0 4100
X 1 4101
# Source 2 disabled with a full queue of four commands
P 1
E b
C 2 1 5000 0
C 2 2 5100 0
C 2 1 5200 0
C 2 1 5300 0
C 1 2 6000 0
X 0 6000
X 1 6001
# Source 2 enabled again
P 0
E f
X 1 5000
X 0 5100
X 1 5101
X 1 5200
X 1 5300

// ==== project.f ====
rtl/noc_pkg.sv
rtl/flit_link_if.sv
rtl/packet_source.sv
rtl/packet_arbiter.sv
rtl/output_port.sv
rtl/noc_output_stage.sv
test/tb_noc_output_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_noc_output_stage -o sim_noc && \
./obj_dir/sim_noc || exit 1
